//--- filelist.f
src/sdram_pkg.sv
src/slot_req_if.sv
src/slot_cache.sv
src/slot_arbiter.sv
src/bank_sequencer.sv
src/sdram_mux.sv
tests/slot_checker.sv
tests/tb_sdram_mux.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SDRAM multiplexer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_sdram_mux \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"

//--- src/bank_sequencer.sv
`timescale 1ns/1ps
// ================================================
// SDRAM bank sequencer
// Runs one access on the bank port with rd/wr,
// ack and rdy, and gates the refresh enable
// ================================================
module bank_sequencer import sdram_pkg::*; #(
    parameter int SDRAM_AW = sdram_aw_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lvbl,
    input  logic                rfsh_en,
    input  logic                ba_ack,
    input  logic                ba_rdy,
    input  logic [data_w-1:0]   data_read,
    output logic [SDRAM_AW-1:0] ba_addr,
    output logic                ba_rd,
    output logic                ba_wr,
    output logic [data_w-1:0]   ba_din,
    output logic [data_w/8-1:0] ba_din_m,  // Write mask, active low
    output logic                refresh_en,
    slot_req_if.server          req_if
);

seq_state_e state;
logic       start;

// req is still high in the cycle of done
assign start = state == SEQ_IDLE && req_if.req && !req_if.done;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state       <= SEQ_IDLE;
        ba_rd       <= 1'b0;
        ba_wr       <= 1'b0;
        req_if.done <= 1'b0;
        refresh_en  <= 1'b0;
    end else begin
        req_if.done <= 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (start) begin
                    ba_rd <= !req_if.we;
                    ba_wr <= req_if.we;
                    state <= SEQ_WAIT_ACK;
                end
            end
            SEQ_WAIT_ACK: begin
                if (ba_ack) begin  // Strobe drops next cycle
                    ba_rd <= 1'b0;
                    ba_wr <= 1'b0;
                    state <= SEQ_WAIT_RDY;
                end
            end
            SEQ_WAIT_RDY: begin
                if (ba_rdy) begin
                    req_if.done <= 1'b1;
                    state       <= SEQ_IDLE;
                end
            end
            default: state <= SEQ_IDLE;
        endcase
        // Refresh only in vertical blank with the bank quiet
        refresh_en <= !lvbl && rfsh_en && state == SEQ_IDLE && !req_if.req;
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        ba_addr  <= req_if.addr;
        ba_din   <= req_if.din;
        ba_din_m <= req_if.mask;
    end
    if (state == SEQ_WAIT_RDY && ba_rdy) begin
        req_if.dout <= data_read;  // Unused by the slot on writes
    end
end

a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ba_rd && ba_wr));

// The bank only acknowledges a raised strobe
a_no_idle_ack: assert property (@(posedge clk) disable iff (!rst_n)
    state == SEQ_IDLE |-> !ba_ack);

endmodule

//--- src/sdram_mux.sv
`timescale 1ns/1ps
// ================================================
// SDRAM bank sharing for work RAM, program ROM
// and sound ROM clients of the arcade core
// ================================================
module sdram_mux import sdram_pkg::*; #(
    parameter int SDRAM_AW = sdram_aw_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lvbl,
    input  logic                rfsh_en,
    input  logic                cache_clr,
    // Main CPU work RAM
    input  logic                ram_cs,
    input  logic                ram_we,
    input  logic [16:0]         ram_addr,
    input  logic [data_w-1:0]   ram_din,
    input  logic [data_w/8-1:0] ram_dsn,
    output logic                ram_ok,
    output logic [data_w-1:0]   ram_data,
    // Main CPU program ROM
    input  logic                rom_cs,
    input  logic [19:0]         rom_addr,
    output logic                rom_ok,
    output logic [data_w-1:0]   rom_data,
    // Sound CPU ROM, byte wide
    input  logic                snd_cs,
    input  logic [15:0]         snd_addr,
    output logic                snd_ok,
    output logic [7:0]          snd_data,
    // SDRAM bank port
    output logic [SDRAM_AW-1:0] ba_addr,
    output logic                ba_rd,
    output logic                ba_wr,
    output logic [data_w-1:0]   ba_din,
    output logic [data_w/8-1:0] ba_din_m,
    input  logic                ba_ack,
    input  logic                ba_rdy,
    input  logic [data_w-1:0]   data_read,
    output logic                refresh_en
);

slot_req_if #(.SDRAM_AW(SDRAM_AW)) slot_bus [3] ();  // Indexed by slot_id_e
slot_req_if #(.SDRAM_AW(SDRAM_AW)) bank_bus ();

slot_cache #(
    .SDRAM_AW ( SDRAM_AW                 ),
    .ADDR_W   ( 17                       ),
    .DATA_W   ( data_w                   ),
    .OFFSET   ( SDRAM_AW'(wram_offset)   ),
    .WRITABLE ( 1'b1                     )
) u_ram_slot (
    .clk       ( clk          ),
    .rst_n     ( rst_n        ),
    .cs        ( ram_cs       ),
    .we        ( ram_we       ),
    .addr      ( ram_addr     ),
    .din       ( ram_din      ),
    .dsn       ( ram_dsn      ),
    .cache_clr ( cache_clr    ),
    .ok        ( ram_ok       ),
    .dout      ( ram_data     ),
    .req_if    ( slot_bus[0]  )
);

slot_cache #(
    .SDRAM_AW ( SDRAM_AW                 ),
    .ADDR_W   ( 20                       ),
    .DATA_W   ( data_w                   ),
    .OFFSET   ( SDRAM_AW'(rom_offset)    ),
    .WRITABLE ( 1'b0                     )
) u_rom_slot (
    .clk       ( clk          ),
    .rst_n     ( rst_n        ),
    .cs        ( rom_cs       ),
    .we        ( 1'b0         ),
    .addr      ( rom_addr     ),
    .din       ( 16'h0        ),
    .dsn       ( 2'b11        ),
    .cache_clr ( cache_clr    ),
    .ok        ( rom_ok       ),
    .dout      ( rom_data     ),
    .req_if    ( slot_bus[1]  )
);

slot_cache #(
    .SDRAM_AW ( SDRAM_AW                 ),
    .ADDR_W   ( 16                       ),
    .DATA_W   ( 8                        ),
    .OFFSET   ( SDRAM_AW'(snd_offset)    ),
    .WRITABLE ( 1'b0                     )
) u_snd_slot (
    .clk       ( clk          ),
    .rst_n     ( rst_n        ),
    .cs        ( snd_cs       ),
    .we        ( 1'b0         ),
    .addr      ( snd_addr     ),
    .din       ( 8'h0         ),
    .dsn       ( 2'b11        ),
    .cache_clr ( cache_clr    ),
    .ok        ( snd_ok       ),
    .dout      ( snd_data     ),
    .req_if    ( slot_bus[2]  )
);

slot_arbiter #(
    .SDRAM_AW ( SDRAM_AW )
) u_arbiter (
    .clk   ( clk      ),
    .rst_n ( rst_n    ),
    .slots ( slot_bus ),
    .bank  ( bank_bus )
);

bank_sequencer #(
    .SDRAM_AW ( SDRAM_AW )
) u_sequencer (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .lvbl       ( lvbl       ),
    .rfsh_en    ( rfsh_en    ),
    .ba_ack     ( ba_ack     ),
    .ba_rdy     ( ba_rdy     ),
    .data_read  ( data_read  ),
    .ba_addr    ( ba_addr    ),
    .ba_rd      ( ba_rd      ),
    .ba_wr      ( ba_wr      ),
    .ba_din     ( ba_din     ),
    .ba_din_m   ( ba_din_m   ),
    .refresh_en ( refresh_en ),
    .req_if     ( bank_bus   )
);

endmodule

//--- src/sdram_pkg.sv
// ================================================
// SDRAM sharing package
// Region offsets, slot and sequencer enums and the
// word widths shared by the bank multiplexer
// ================================================
package sdram_pkg;

// SDRAM word address width used when the top sets no other
localparam int sdram_aw_default = 22;

// Bank data word, two bytes
localparam int data_w = 16;

// Word offsets of each client region in the bank
localparam logic [sdram_aw_default-1:0] wram_offset = 22'h30_0000;  // Main CPU work RAM
localparam logic [sdram_aw_default-1:0] rom_offset  = 22'h00_0000;  // Main CPU program
localparam logic [sdram_aw_default-1:0] snd_offset  = 22'h38_0000;  // Sound CPU program

// Slot order is also the round-robin order
typedef enum logic [1:0] {
    SLOT_RAM = 2'd0,
    SLOT_ROM = 2'd1,
    SLOT_SND = 2'd2
} slot_id_e;

// Bank sequencer states
typedef enum logic [1:0] {
    SEQ_IDLE     = 2'd0,  // Waiting for a granted request
    SEQ_WAIT_ACK = 2'd1,  // Strobe high until the bank takes it
    SEQ_WAIT_RDY = 2'd2   // Data or write completion pending
} seq_state_e;

endpackage

//--- src/slot_arbiter.sv
`timescale 1ns/1ps
// ================================================
// Round-robin arbiter over the three slots
// Forwards one request at a time to the sequencer
// ================================================
module slot_arbiter import sdram_pkg::*; #(
    parameter int SDRAM_AW = sdram_aw_default
) (
    input  logic          clk,
    input  logic          rst_n,
    slot_req_if.server    slots [3],
    slot_req_if.requester bank
);

logic [2:0]          pend;
logic [2:0]          done_vec;
logic [2:0]          s_we;
logic [SDRAM_AW-1:0] s_addr [3];
logic [data_w-1:0]   s_din  [3];
logic [data_w/8-1:0] s_mask [3];
slot_id_e            last;  // Last granted slot, owner while bank.req is high
slot_id_e            pick;
slot_id_e            cand;
logic                found;
logic                grant_now;

// Interface arrays only take constant indexes
for (genvar i = 0; i < 3; i++) begin : g_slot
    assign pend[i]       = slots[i].req;
    assign s_we[i]       = slots[i].we;
    assign s_addr[i]     = slots[i].addr;
    assign s_din[i]      = slots[i].din;
    assign s_mask[i]     = slots[i].mask;
    assign done_vec[i]   = bank.done && last == slot_id_e'(i);
    assign slots[i].done = done_vec[i];
    assign slots[i].dout = bank.dout;
end

// First pending slot after the last granted one
always_comb begin
    pick  = last;
    found = 1'b0;
    cand  = last;
    for (int k = 1; k <= 3; k++) begin
        cand = slot_id_e'((int'(last) + k) % 3);
        if (!found && pend[cand]) begin
            pick  = cand;
            found = 1'b1;
        end
    end
end

assign grant_now = !bank.req && found;  // Sequencer free

always_ff @(posedge clk) begin
    if (!rst_n) begin
        bank.req <= 1'b0;
        last     <= SLOT_SND;  // RAM goes first
    end else if (bank.done) begin
        bank.req <= 1'b0;
    end else if (grant_now) begin
        bank.req <= 1'b1;
        last     <= pick;
    end
end

// Slot fields are stable while its req is high
always_ff @(posedge clk) begin
    if (grant_now) begin
        bank.we   <= s_we[pick];
        bank.addr <= s_addr[pick];
        bank.din  <= s_din[pick];
        bank.mask <= s_mask[pick];
    end
end

a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(done_vec));

endmodule

//--- src/slot_cache.sv
`timescale 1ns/1ps
// ================================================
// Client slot stage with a one word cache
// Adds the region offset and requests the bank
// on a read miss or on any write
// ================================================
module slot_cache import sdram_pkg::*; #(
    parameter int                  SDRAM_AW = sdram_aw_default,
    parameter int                  ADDR_W   = 17,
    parameter int                  DATA_W   = 16,
    parameter logic [SDRAM_AW-1:0] OFFSET   = '0,
    parameter bit                  WRITABLE = 1'b0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cs,
    input  logic                we,
    input  logic [ADDR_W-1:0]   addr,
    input  logic [DATA_W-1:0]   din,
    input  logic [data_w/8-1:0] dsn,
    input  logic                cache_clr,
    output logic                ok,
    output logic [DATA_W-1:0]   dout,
    slot_req_if.requester       req_if
);

localparam int SHIFT = (DATA_W == 8) ? 1 : 0;  // Byte clients drop the LSB

logic [SDRAM_AW-1:0] sd_addr;
logic [SDRAM_AW-1:0] cache_addr;
logic [data_w-1:0]   cache_data;
logic [data_w-1:0]   merged;
logic                cache_valid;
logic                wr;
logic                hit;
logic                issue;
logic                ok_q;
logic                ok_we;
logic [ADDR_W-1:0]   ok_addr;  // Client address seen last cycle

assign sd_addr = OFFSET + SDRAM_AW'(addr >> SHIFT);
assign wr      = cs && we && WRITABLE;
assign hit     = cache_valid && cache_addr == sd_addr;

// Address and direction must not move since ok_q was set
assign ok = cs && ok_q && ok_addr == addr && ok_we == wr;

// A finished write keeps ok_q, so it is never sent twice
assign issue = cs && !req_if.req && (wr ? !(ok_q && ok_we && ok_addr == addr) : !hit);

// Write data under the active low byte mask
always_comb begin
    merged = cache_data;
    for (int b = 0; b < data_w / 8; b++) begin
        if (!req_if.mask[b]) begin
            merged[b*8 +: 8] = req_if.din[b*8 +: 8];
        end
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        req_if.req  <= 1'b0;
        cache_valid <= 1'b0;
        ok_q        <= 1'b0;
        ok_we       <= 1'b0;
    end else begin
        if (req_if.done) begin
            req_if.req <= 1'b0;
            if (!req_if.we) begin
                cache_valid <= 1'b1;  // Fresh word from the bank
            end
        end else if (issue) begin
            req_if.req <= 1'b1;
        end
        if (cache_clr) begin
            cache_valid <= 1'b0;
        end
        if (req_if.done && req_if.we) begin
            ok_q <= 1'b1;
        end else if (wr) begin
            ok_q <= ok_q && ok_we && ok_addr == addr;
        end else begin
            ok_q <= cs && hit && !cache_clr;  // Registered hit
        end
        ok_we <= wr;
    end
end

always_ff @(posedge clk) begin
    ok_addr <= addr;
    if (issue) begin
        req_if.we   <= wr;
        req_if.addr <= sd_addr;
        req_if.din  <= {(data_w / DATA_W){din}};  // Byte data lands on both lanes
        req_if.mask <= dsn;
    end
    if (req_if.done) begin
        if (!req_if.we) begin
            cache_data <= req_if.dout;
            cache_addr <= req_if.addr;
        end else if (cache_valid && cache_addr == req_if.addr) begin
            cache_data <= merged;  // Keep the cached copy coherent
        end
    end
end

generate
    if (DATA_W == 8) begin : g_byte
        assign dout = addr[0] ? cache_data[15:8] : cache_data[7:0];
    end else begin : g_word
        assign dout = cache_data[DATA_W-1:0];
    end
endgenerate

// Read only regions never see a write
a_no_rom_write: assert property (@(posedge clk) disable iff (!rst_n)
    !WRITABLE |-> !(cs && we));

endmodule

//--- src/slot_req_if.sv
`timescale 1ns/1ps
// ================================================
// Request bus between two pipeline stages
// One access travels out, done and data come back
// ================================================
interface slot_req_if import sdram_pkg::*; #(
    parameter int SDRAM_AW = sdram_aw_default
);

    logic                req;   // Level, held until done
    logic                we;
    logic [SDRAM_AW-1:0] addr;  // Region offset already added
    logic [data_w-1:0]   din;
    logic [data_w/8-1:0] mask;  // Active low per byte
    logic                done;  // Single cycle pulse
    logic [data_w-1:0]   dout;

    // Side that issues the access
    modport requester (
        output req, we, addr, din, mask,
        input  done, dout
    );

    // Side that carries it out
    modport server (
        input  req, we, addr, din, mask,
        output done, dout
    );

endinterface

//--- tests/slot_checker.sv
`timescale 1ns/1ps
// ================================================
// Scoreboard for the SDRAM bank multiplexer
// Reference memory, client data, bank accesses,
// arbitration fairness and refresh gating
// ================================================
module slot_checker import sdram_pkg::*; #(
    parameter int SDRAM_AW = sdram_aw_default
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          test_id,
    input  logic [1:0]          expect_bank,  // 0 any, 1 no bank read, 2 one bank read
    input  logic                lvbl,
    input  logic                rfsh_en,
    input  logic                ram_cs,
    input  logic                ram_we,
    input  logic [16:0]         ram_addr,
    input  logic [15:0]         ram_din,
    input  logic [1:0]          ram_dsn,
    input  logic                ram_ok,
    input  logic [15:0]         ram_data,
    input  logic                rom_cs,
    input  logic [19:0]         rom_addr,
    input  logic                rom_ok,
    input  logic [15:0]         rom_data,
    input  logic                snd_cs,
    input  logic [15:0]         snd_addr,
    input  logic                snd_ok,
    input  logic [7:0]          snd_data,
    input  logic [SDRAM_AW-1:0] ba_addr,
    input  logic                ba_rd,
    input  logic                ba_wr,
    input  logic [15:0]         ba_din,
    input  logic [1:0]          ba_din_m,
    input  logic                refresh_en,
    output int                  error_count,
    output int                  check_count
);

logic [15:0]         ref_mem [int];
logic [2:0]          cur_id;
int                  t_checks;
int                  t_errors;
int                  bank_cnt;      // Strobes since the last completed access
int                  rfsh_seen;
int                  wait_idx [3];
int                  wait_grants [3];
logic [SDRAM_AW-1:0] last_rd_addr;
logic [SDRAM_AW-1:0] a;
logic [15:0]         w;
logic                prev_strobe;
logic                prev_rst;
logic                p_lvbl;
logic                p_rfsh;
logic                strobe_rise;
logic [2:0]          prev_cs;
logic [2:0]          cs_v;
logic [2:0]          ok_v;

initial begin
    error_count = 0;
    check_count = 0;
    cur_id      = 3'd0;
    t_checks    = 0;
    t_errors    = 0;
    rfsh_seen   = 0;
    prev_rst    = 1'b0;
end

function automatic string name_of(input logic [2:0] id);
    case (id)
        3'd1:    return "rom_read";
        3'd2:    return "snd_read";
        3'd3:    return "ram_write_read";
        3'd4:    return "cache_hit";
        3'd5:    return "contention";
        3'd6:    return "refresh";
        default: return "idle";
    endcase
endfunction

// Untouched words follow the power-up pattern
function automatic logic [15:0] word_at(input logic [SDRAM_AW-1:0] addr);
    if (ref_mem.exists(int'(addr))) begin
        return ref_mem[int'(addr)];
    end
    return addr[15:0] ^ 16'h5a5a;
endfunction

function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] din,
                                      input logic [1:0] dsn);
    logic [15:0] res;
    res = old;
    if (!dsn[0]) res[7:0] = din[7:0];     // Active low byte enables
    if (!dsn[1]) res[15:8] = din[15:8];
    return res;
endfunction

task automatic compare_value(input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    t_checks++;
    if (exp !== act) begin
        error_count++;
        t_errors++;
        $display("Error %s: expected %h, actual %h", name_of(cur_id), exp, act);
    end
endtask

task automatic flag_error(input string msg);
    error_count++;
    t_errors++;
    $display("Error %s: %s", name_of(cur_id), msg);
endtask

// Bank read count since the previous completion
task automatic check_bank();
    if (expect_bank == 2'd1) compare_value(32'd0, bank_cnt);
    if (expect_bank == 2'd2) compare_value(32'd1, bank_cnt);
    bank_cnt = 0;
endtask

always @(negedge clk) begin
    if (test_id != cur_id) begin
        if (cur_id == 3'd6 && rfsh_seen == 0) begin
            flag_error("refresh_en never went high during vertical blank");
        end
        if (cur_id >= 3'd1 && cur_id <= 3'd6) begin
            $display("Test %s finished: %0d checks, %0d errors",
                     name_of(cur_id), t_checks, t_errors);
        end
        cur_id    = test_id;
        t_checks  = 0;
        t_errors  = 0;
        rfsh_seen = 0;
    end
    if (!rst_n) begin
        prev_strobe = 1'b0;
        prev_cs     = 3'b000;
        bank_cnt    = 0;
        p_lvbl      = 1'b1;
        p_rfsh      = 1'b0;
    end else begin
        if (!prev_rst && refresh_en) begin
            flag_error("refresh_en is high right after reset");
        end
        // Registered enable follows last cycle's conditions
        if (refresh_en && !(!p_lvbl && p_rfsh && !prev_strobe)) begin
            flag_error("refresh_en is high outside vertical blank or with the bank busy");
        end
        if (refresh_en) rfsh_seen++;
        strobe_rise = (ba_rd || ba_wr) && !prev_strobe;
        if (strobe_rise) begin
            bank_cnt++;
            if (ba_rd) last_rd_addr = ba_addr;
            // Only the RAM client writes and it holds its fields until ok
            if (ba_wr) begin
                if (!(ram_cs && ram_we)) begin
                    flag_error("a bank write started with no RAM write pending");
                end
                a = SDRAM_AW'(wram_offset) + SDRAM_AW'(ram_addr);
                compare_value(32'(a), 32'(ba_addr));
                compare_value(32'(ram_din), 32'(ba_din));
                compare_value(32'(ram_dsn), 32'(ba_din_m));
            end
        end
        cs_v = {snd_cs, rom_cs, ram_cs};
        ok_v = {snd_ok, rom_ok, ram_ok};
        for (int c = 0; c < 3; c++) begin
            if (cs_v[c] && !prev_cs[c]) begin
                wait_idx[c]    = 0;
                wait_grants[c] = 0;
            end else if (cs_v[c]) begin
                wait_idx[c]++;
                // Strobes from grants made before this request was pending are skipped
                if (strobe_rise && wait_idx[c] >= 3) wait_grants[c]++;
            end
            if (cs_v[c] && ok_v[c] && cur_id == 3'd5 && wait_grants[c] > 3) begin
                flag_error("a client waited for more than two other accesses");
            end
        end
        if (rom_cs && rom_ok) begin
            a = SDRAM_AW'(rom_offset) + SDRAM_AW'(rom_addr);
            if (cur_id == 3'd1 && bank_cnt > 0) compare_value(32'(a), 32'(last_rd_addr));
            compare_value(32'(word_at(a)), 32'(rom_data));
            check_bank();
        end
        if (snd_cs && snd_ok) begin
            a = SDRAM_AW'(snd_offset) + SDRAM_AW'(snd_addr >> 1);
            w = word_at(a);
            compare_value(32'(snd_addr[0] ? w[15:8] : w[7:0]), 32'(snd_data));
            check_bank();
        end
        if (ram_cs && ram_ok) begin
            a = SDRAM_AW'(wram_offset) + SDRAM_AW'(ram_addr);
            if (ram_we) begin
                ref_mem[int'(a)] = merge(word_at(a), ram_din, ram_dsn);
                bank_cnt = 0;
            end else begin
                compare_value(32'(word_at(a)), 32'(ram_data));
                check_bank();
            end
        end
        prev_strobe = ba_rd || ba_wr;
        prev_cs     = cs_v;
        p_lvbl      = lvbl;
        p_rfsh      = rfsh_en;
    end
    prev_rst = rst_n;
end

endmodule

//--- tests/tb_sdram_mux.sv
`timescale 1ns/1ps
// ================================================
// Testbench for the SDRAM bank multiplexer
// Random client traffic against a bank model
// ================================================
module tb_sdram_mux import sdram_pkg::*; ();

localparam int AW        = sdram_aw_default;
localparam int TOTAL_OPS = 40 + 40 + 63 + 9 + 60 + 20 + 10;
localparam int WD_CYCLES = TOTAL_OPS * 40 + 500;

logic clk, rst_n, lvbl, rfsh_en, cache_clr;
logic ram_cs, ram_we, ram_ok, rom_cs, rom_ok, snd_cs, snd_ok;
logic [16:0] ram_addr;
logic [15:0] ram_din, ram_data, rom_data, snd_addr, data_read, ba_din;
logic [1:0] ram_dsn, ba_din_m, expect_bank;
logic [19:0] rom_addr;
logic [7:0] snd_data;
logic [AW-1:0] ba_addr, rsp_addr;
logic ba_rd, ba_wr, ba_ack, ba_rdy, refresh_en, rsp_we;
logic [15:0] rsp_din, rsp_word;
logic [1:0] rsp_mask;
logic [2:0] test_id;
logic [31:0] seed;
logic [15:0] sdram_mem [int];
int rsp_state, rsp_cnt, errors, checks;

sdram_mux #(.SDRAM_AW(AW)) UUT (
    .clk(clk), .rst_n(rst_n), .lvbl(lvbl), .rfsh_en(rfsh_en), .cache_clr(cache_clr),
    .ram_cs(ram_cs), .ram_we(ram_we), .ram_addr(ram_addr), .ram_din(ram_din),
    .ram_dsn(ram_dsn), .ram_ok(ram_ok), .ram_data(ram_data),
    .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
    .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
    .ba_addr(ba_addr), .ba_rd(ba_rd), .ba_wr(ba_wr), .ba_din(ba_din),
    .ba_din_m(ba_din_m), .ba_ack(ba_ack), .ba_rdy(ba_rdy), .data_read(data_read),
    .refresh_en(refresh_en)
);

slot_checker #(.SDRAM_AW(AW)) u_checker (
    .clk(clk), .rst_n(rst_n), .test_id(test_id), .expect_bank(expect_bank),
    .lvbl(lvbl), .rfsh_en(rfsh_en),
    .ram_cs(ram_cs), .ram_we(ram_we), .ram_addr(ram_addr), .ram_din(ram_din),
    .ram_dsn(ram_dsn), .ram_ok(ram_ok), .ram_data(ram_data),
    .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
    .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
    .ba_addr(ba_addr), .ba_rd(ba_rd), .ba_wr(ba_wr), .ba_din(ba_din),
    .ba_din_m(ba_din_m), .refresh_en(refresh_en),
    .error_count(errors), .check_count(checks)
);

function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// Bank model with ack after 1 to 3 cycles and rdy 2 to 4 cycles later
always @(posedge clk) begin
    if (!rst_n) begin
        ba_ack    <= 1'b0;
        ba_rdy    <= 1'b0;
        rsp_state <= 0;
    end else begin
        ba_ack <= 1'b0;
        ba_rdy <= 1'b0;
        case (rsp_state)
            0: if (ba_rd || ba_wr) begin
                rsp_addr  <= ba_addr;
                rsp_we    <= ba_wr;
                rsp_din   <= ba_din;
                rsp_mask  <= ba_din_m;
                rsp_cnt   <= 1 + int'((next_rand() >> 16) % 3);
                rsp_state <= 1;
            end
            1: if (rsp_cnt == 1) begin
                ba_ack    <= 1'b1;
                rsp_cnt   <= 2 + int'((next_rand() >> 16) % 3);
                rsp_state <= 2;
            end else begin
                rsp_cnt <= rsp_cnt - 1;
            end
            default: if (rsp_cnt == 1) begin
                rsp_word = sdram_mem.exists(int'(rsp_addr)) ? sdram_mem[int'(rsp_addr)]
                                                            : rsp_addr[15:0] ^ 16'h5a5a;
                if (rsp_we) begin
                    if (!rsp_mask[0]) rsp_word[7:0] = rsp_din[7:0];
                    if (!rsp_mask[1]) rsp_word[15:8] = rsp_din[15:8];
                    sdram_mem[int'(rsp_addr)] = rsp_word;
                end
                data_read <= rsp_word;
                ba_rdy    <= 1'b1;
                rsp_state <= 0;
            end else begin
                rsp_cnt <= rsp_cnt - 1;
            end
        endcase
    end
end

task automatic rom_read(input logic [19:0] a, input logic [1:0] eb);
    @(posedge clk);
    rom_cs      <= 1'b1;
    rom_addr    <= a;
    expect_bank <= eb;
    do @(negedge clk); while (!rom_ok);
    @(posedge clk);
    rom_cs <= 1'b0;
endtask

task automatic snd_read(input logic [15:0] a, input logic [1:0] eb);
    @(posedge clk);
    snd_cs      <= 1'b1;
    snd_addr    <= a;
    expect_bank <= eb;
    do @(negedge clk); while (!snd_ok);
    @(posedge clk);
    snd_cs <= 1'b0;
endtask

task automatic ram_access(input logic we, input logic [16:0] a, input logic [15:0] d,
                          input logic [1:0] dsn, input logic [1:0] eb);
    @(posedge clk);
    ram_cs      <= 1'b1;
    ram_we      <= we;
    ram_addr    <= a;
    ram_din     <= d;
    ram_dsn     <= dsn;
    expect_bank <= eb;
    do @(negedge clk); while (!ram_ok);
    @(posedge clk);
    ram_cs <= 1'b0;
    ram_we <= 1'b0;
endtask

task automatic random_ram_op();
    logic [31:0] r;
    r = next_rand();
    ram_access(r[31], 17'h100 + 17'(r[26:24]), r[23:8], r[7:6], 2'd0);  // Eight hot words
endtask

task automatic clear_caches();
    @(posedge clk);
    cache_clr <= 1'b1;
    @(posedge clk);
    cache_clr <= 1'b0;
endtask

task automatic start_test(input logic [2:0] id);
    @(posedge clk);
    test_id     <= id;
    expect_bank <= 2'd0;
endtask

initial begin
    seed = 32'h77f7c42c;
    {rst_n, cache_clr, rfsh_en, ram_cs, ram_we, rom_cs, snd_cs} = '0;
    lvbl        = 1'b1;
    ram_addr    = '0;
    ram_din     = '0;
    ram_dsn     = 2'b11;
    rom_addr    = '0;
    snd_addr    = '0;
    ba_ack      = 1'b0;
    ba_rdy      = 1'b0;
    data_read   = '0;
    test_id     = 3'd0;
    expect_bank = 2'd0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    start_test(3'd1);
    for (int i = 0; i < 40; i++) rom_read(20'(next_rand() >> 8), 2'd0);
    start_test(3'd2);
    for (int i = 0; i < 40; i++) snd_read(16'(next_rand() >> 12), 2'd0);
    start_test(3'd3);
    for (int i = 0; i < 60; i++) random_ram_op();
    ram_access(1'b0, 17'h0105, 16'h0, 2'b11, 2'd0);
    ram_access(1'b1, 17'h0105, 16'hc3a5, 2'b10, 2'd0);  // Low byte only
    ram_access(1'b0, 17'h0105, 16'h0, 2'b11, 2'd1);     // Merged word from the cache
    start_test(3'd4);
    rom_read(20'h1234, 2'd0);
    rom_read(20'h1234, 2'd1);
    clear_caches();
    rom_read(20'h1234, 2'd2);
    snd_read(16'h0a51, 2'd0);
    snd_read(16'h0a51, 2'd1);
    clear_caches();
    snd_read(16'h0a51, 2'd2);
    ram_access(1'b0, 17'h0777, 16'h0, 2'b11, 2'd0);
    ram_access(1'b0, 17'h0777, 16'h0, 2'b11, 2'd1);
    clear_caches();
    ram_access(1'b0, 17'h0777, 16'h0, 2'b11, 2'd2);
    start_test(3'd5);
    fork
        for (int i = 0; i < 20; i++) rom_read(20'(next_rand() >> 8), 2'd0);
        for (int j = 0; j < 20; j++) snd_read(16'(next_rand() >> 12), 2'd0);
        for (int k = 0; k < 20; k++) random_ram_op();
    join
    start_test(3'd6);
    for (int i = 0; i < 20; i++) begin
        @(posedge clk);
        lvbl    <= seed[30];
        rfsh_en <= seed[29];
        rom_read(20'(next_rand() >> 8), 2'd0);
    end
    @(posedge clk);
    lvbl    <= 1'b0;  // Vertical blank with refresh allowed
    rfsh_en <= 1'b1;
    repeat (10) @(posedge clk);
    lvbl    <= 1'b1;
    rfsh_en <= 1'b0;
    start_test(3'd7);
    repeat (2) @(negedge clk);
    $display("All tests finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Done: errors found");
    $finish;
end

endmodule
